/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_audio_mix
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides the result, not the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
source/audio_mix_pkg.sv
source/host_cmd_decoder.sv
source/frame_splitter.sv
source/channel_mixer.sv
source/frame_collector.sv
source/audio_mix_top.sv
sim/tb_audio_mix.sv

/* sim/tb_audio_mix.sv */
/* Mode and attenuation change only while the pipeline is empty.
   All DUT inputs come from one stimulus process, so random draws keep a fixed order. */
module tb_audio_mix
	import audio_mix_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// All tests take well under 1000 cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic             clk;
	logic             resetd;
	logic             i_host_valid;
	host_word_t       i_host;
	logic             i_in_valid;
	in_frame_t        i_in;
	logic             i_out_ready;
	mix_mode_e        i_mix_mode;
	logic             o_host_ready;
	logic             o_in_ready;
	logic             o_out_valid;
	out_frame_t       o_out;
	out_frame_t       exp_q[$];
	int               errors = 0;
	int               err_mark = 0;
	int               sent_count = 0;
	int               sent_mark = 0;
	int               recv_count = 0;
	int               test_count = 0;
	int               cycles = 0;
	logic             bp_active = 1'b0;
	logic [ATT_W-1:0] cur_att = '0;

	audio_mix_top u_audio_mix_top (
		.clk          (clk),
		.resetd       (resetd),
		.i_host_valid (i_host_valid),
		.o_host_ready (o_host_ready),
		.i_host       (i_host),
		.i_in_valid   (i_in_valid),
		.o_in_ready   (o_in_ready),
		.i_in         (i_in),
		.o_out_valid  (o_out_valid),
		.i_out_ready  (i_out_ready),
		.o_out        (o_out),
		.i_mix_mode   (i_mix_mode)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reference model and helpers
	////////////////////////////////////////////////////////////

	function automatic out_frame_t mix_ref(input in_frame_t f, input mix_mode_e mode,
		input logic [ATT_W-1:0] att);
		out_frame_t r;
		int         sum [N_CHANNELS];
		int         part;
		int         mixed;
		// Offset binary core is halved with zero fill
		for (int ch = 0; ch < N_CHANNELS; ch++) begin
			sum[ch] = (f.is_signed ? int'($signed(f.core[ch])) : int'(f.core[ch]) / 2)
				+ int'($signed(f.host[ch]));
		end
		for (int ch = 0; ch < N_CHANNELS; ch++) begin
			part = sum[ch ^ 1] >>> 1;
			case (mode)
				MIX_LIGHT:  mixed = sum[ch] - (sum[ch] >>> 3) + (part >>> 2);
				MIX_MEDIUM: mixed = sum[ch] - (sum[ch] >>> 2) + (part >>> 1);
				MIX_MONO:   mixed = (sum[ch] >>> 1) + part;
				default:    mixed = sum[ch];
			endcase
			mixed = att[ATT_W-1] ? 0 : mixed >>> att[ATT_W-2:0];
			r.sample[ch] = (mixed > 32767) ? 16'h7fff :
				(mixed < -32768) ? 16'h8000 : mixed[SAMPLE_W-1:0];
		end
		return r;
	endfunction

	function automatic in_frame_t rand_frame(input logic is_signed);
		in_frame_t f;
		for (int ch = 0; ch < N_CHANNELS; ch++) begin
			f.core[ch] = 16'($urandom);
			f.host[ch] = 16'($urandom);
		end
		f.is_signed = is_signed;
		return f;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("CHECK FAILED at %0t: %s expected %0h, actual %0h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic report(input string name);
		$display("%-14s frames %0d, errors %0d", name, sent_count - sent_mark, errors - err_mark);
		sent_mark = sent_count;
		err_mark  = errors;
		test_count++;
	endtask

	task automatic update_out_ready();
		i_out_ready = bp_active ? 1'($urandom_range(0, 1)) : 1'b1;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			i_in_valid   = 1'b0;
			i_host_valid = 1'b0;
			update_out_ready();
		end
	endtask

	// Returns right after the handshake edge
	task automatic send_frame(input in_frame_t f, input out_frame_t expected);
		@(negedge clk);
		i_in       = f;
		i_in_valid = 1'b1;
		update_out_ready();
		while (!o_in_ready) begin
			@(negedge clk);
			update_out_ready();
		end
		@(posedge clk);
		exp_q.push_back(expected);
		sent_count++;
	endtask

	task automatic drain();
		int waited;
		waited    = 0;
		bp_active = 1'b0;
		while (exp_q.size() != 0 && waited < 64) begin
			idle(1);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("ERROR at %0t: %0d frames never left the DUT", $time, exp_q.size());
			errors++;
		end
		idle(4);
	endtask

	// sign_sel 0 offset binary, 1 two's complement, 2 random per frame
	task automatic run_frames(input int n, input int sign_sel, input mix_mode_e mode);
		in_frame_t f;
		@(negedge clk);
		i_mix_mode = mode;
		repeat (n) begin
			f = rand_frame(sign_sel == 2 ? 1'($urandom_range(0, 1)) : 1'(sign_sel));
			send_frame(f, mix_ref(f, mode, cur_att));
			if (bp_active && $urandom_range(0, 2) == 0) begin
				idle(1);
			end
		end
		drain();
	endtask

	task automatic send_host(input logic start, input logic [HOST_W-1:0] data);
		@(negedge clk);
		i_host       = '{start, data};
		i_host_valid = 1'b1;
		while (!o_host_ready) @(negedge clk);
	endtask

	task automatic set_volume(input logic [ATT_W-1:0] val);
		send_host(1'b1, 16'h0026);
		send_host(1'b0, {11'($urandom), val});
		idle(8);
		cur_att = val;
	endtask

	////////////////////////////////////////////////////////////
	// Output comparator and run limit
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		out_frame_t exp_frame;
		if (!resetd && o_out_valid && i_out_ready) begin
			if (exp_q.size() == 0) begin
				$display("ERROR at %0t: DUT sent a frame that was never offered", $time);
				errors++;
			end else begin
				exp_frame = exp_q.pop_front();
				recv_count++;
				check_value("o_out.sample[0]", int'(exp_frame.sample[0]), int'(o_out.sample[0]));
				check_value("o_out.sample[1]", int'(exp_frame.sample[1]), int'(o_out.sample[1]));
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		int        lat;
		in_frame_t f;
		void'($urandom(32'hc93b5c74));
		resetd       = 1'b1;
		i_host_valid = 1'b0;
		i_host       = '0;
		i_in_valid   = 1'b0;
		i_in         = '0;
		i_out_ready  = 1'b1;
		i_mix_mode   = MIX_NONE;
		repeat (3) @(posedge clk);
		@(negedge clk);
		resetd = 1'b0;
		check_value("o_out_valid", 0, int'(o_out_valid));
		check_value("o_in_ready", 1, int'(o_in_ready));
		check_value("o_host_ready", 1, int'(o_host_ready));
		report("reset_state");

		// Single frame into an empty pipeline for the latency count
		f = rand_frame(1'b1);
		send_frame(f, mix_ref(f, MIX_NONE, cur_att));
		lat = 0;
		idle(1);
		while (!o_out_valid && lat < 20) begin
			idle(1);
			lat++;
		end
		check_value("o_out_valid latency", 5, lat);
		run_frames(20, 1, MIX_NONE);
		report("pass_through");

		run_frames(16, 0, MIX_NONE);
		report("unsigned_core");

		for (int m = 0; m < 4; m++) begin
			run_frames(16, 2, mix_mode_e'(m));
		end
		report("crossfeed");

		// No command seen since reset, so this word is dropped
		send_host(1'b0, 16'h0007);
		idle(8);
		run_frames(3, 2, MIX_NONE);
		for (int s = 0; s < 16; s++) begin
			set_volume(5'(s));
			run_frames(3, 2, MIX_NONE);
		end
		set_volume(5'h13);
		repeat (3) begin
			f = rand_frame(1'b1);
			send_frame(f, '0);
		end
		drain();
		set_volume(5'd3);
		send_host(1'b1, 16'h0031);
		send_host(1'b0, 16'h0005);
		idle(8);
		run_frames(3, 2, MIX_NONE);
		set_volume(5'd0);
		report("volume");

		@(negedge clk);
		i_mix_mode = MIX_MONO;
		repeat (2) begin
			f.core      = {2{16'h7fff}};
			f.host      = f.core;
			f.is_signed = 1'b1;
			send_frame(f, {2{16'h7fff}});
			f.core = {2{16'h8000}};
			f.host = f.core;
			send_frame(f, {2{16'h8000}});
		end
		drain();
		report("saturation");

		bp_active = 1'b1;
		run_frames(40, 2, MIX_MEDIUM);
		report("back_pressure");

		check_value("frames received", sent_count, recv_count);
		$display("Summary: %0d tests, %0d frames sent, %0d received, %0d errors",
			test_count, sent_count, recv_count, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* source/audio_mix_pkg.sv */
/* Fixed stereo layout, where channel i blends with channel i xor 1.
   Attenuation bit 4 mutes and bits 3:0 give a right shift. */
package audio_mix_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int N_CHANNELS = 2;
	localparam int SAMPLE_W   = 16;
	localparam int WIDE_W     = 17;
	localparam int ATT_W      = 5;
	localparam int HOST_W     = 16;
	localparam int CMD_W      = 8;

	////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////

	// Host command codes, only volume is acted on
	typedef enum logic [CMD_W-1:0] {
		CMD_NONE   = 8'h00,
		CMD_VOLUME = 8'h26
	} host_cmd_e;

	// Crossfeed strength
	typedef enum logic [1:0] {
		MIX_NONE   = 2'd0,
		MIX_LIGHT  = 2'd1,
		MIX_MEDIUM = 2'd2,
		MIX_MONO   = 2'd3
	} mix_mode_e;

	////////////////////////////////////////////////////////////
	// Transfer types
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic              start;
		logic [HOST_W-1:0] data;
	} host_word_t;

	// Index 0 is left, index 1 is right
	typedef struct packed {
		logic [N_CHANNELS-1:0][SAMPLE_W-1:0] core;
		logic [N_CHANNELS-1:0][SAMPLE_W-1:0] host;
		logic                                is_signed;
	} in_frame_t;

	typedef struct packed {
		logic [N_CHANNELS-1:0][SAMPLE_W-1:0] sample;
	} out_frame_t;

	// One channel's share of an input frame
	typedef struct packed {
		logic [SAMPLE_W-1:0] core;
		logic [SAMPLE_W-1:0] host;
		logic                is_signed;
	} chan_sample_t;

endpackage

/* source/audio_mix_top.sv */
/* Single clock stereo mixer. An input frame shows on o_out five edges after its
   handshake when the output is not stalled. */
module audio_mix_top
	import audio_mix_pkg::*;
(
	input  logic       clk,
	input  logic       resetd,
	input  logic       i_host_valid,
	output logic       o_host_ready,
	input  host_word_t i_host,
	input  logic       i_in_valid,
	output logic       o_in_ready,
	input  in_frame_t  i_in,
	output logic       o_out_valid,
	input  logic       i_out_ready,
	output out_frame_t o_out,
	input  mix_mode_e  i_mix_mode
);

	logic [ATT_W-1:0]                    att;
	logic                                advance;
	logic                                stage_valid;
	chan_sample_t [N_CHANNELS-1:0]       chan;
	logic [N_CHANNELS-1:0][SAMPLE_W-1:0] half;
	logic [N_CHANNELS-1:0][SAMPLE_W-1:0] result;
	logic [N_CHANNELS-1:0]               mix_valid;

	host_cmd_decoder u_host_cmd_decoder (
		.clk          (clk),
		.resetd       (resetd),
		.i_host_valid (i_host_valid),
		.i_host       (i_host),
		.o_host_ready (o_host_ready),
		.o_att        (att)
	);

	frame_splitter u_frame_splitter (
		.clk           (clk),
		.resetd        (resetd),
		.i_in_valid    (i_in_valid),
		.i_in          (i_in),
		.i_advance     (advance),
		.o_in_ready    (o_in_ready),
		.o_stage_valid (stage_valid),
		.o_chan        (chan)
	);

	////////////////////////////////////////////////////////////
	// Channel mixers, each fed by its partner's half-sum
	////////////////////////////////////////////////////////////

	for (genvar ch = 0; ch < N_CHANNELS; ch++) begin : g_chan
		channel_mixer u_channel_mixer (
			.clk            (clk),
			.resetd         (resetd),
			.i_advance      (advance),
			.i_valid        (stage_valid),
			.i_sample       (chan[ch]),
			.i_mix_mode     (i_mix_mode),
			.i_att          (att),
			.i_partner_half (half[ch ^ 1]),
			.o_half         (half[ch]),
			.o_valid        (mix_valid[ch]),
			.o_result       (result[ch])
		);
	end

	// All channels step together, so channel 0 speaks for the frame
	frame_collector u_frame_collector (
		.clk         (clk),
		.resetd      (resetd),
		.i_valid     (mix_valid[0]),
		.i_result    (result),
		.i_out_ready (i_out_ready),
		.o_advance   (advance),
		.o_out_valid (o_out_valid),
		.o_out       (o_out)
	);

endmodule

/* source/channel_mixer.sv */
/* Four stages that all move on i_advance. The partner half-sum must come from
   the partner's stage 2 so that both sides hold the same frame. */
module channel_mixer
	import audio_mix_pkg::*;
(
	input  logic                clk,
	input  logic                resetd,
	input  logic                i_advance,
	input  logic                i_valid,
	input  chan_sample_t        i_sample,
	input  mix_mode_e           i_mix_mode,
	input  logic [ATT_W-1:0]    i_att,
	input  logic [SAMPLE_W-1:0] i_partner_half,
	output logic [SAMPLE_W-1:0] o_half,
	output logic                o_valid,
	output logic [SAMPLE_W-1:0] o_result
);

	logic                       v1_q;
	logic                       v2_q;
	logic                       v3_q;
	logic                       v4_q;
	logic signed [WIDE_W-1:0]   s1_core_q;
	logic        [SAMPLE_W-1:0] s1_host_q;
	logic signed [WIDE_W-1:0]   s2_sum_q;
	logic signed [WIDE_W-1:0]   s3_mix_q;
	logic        [SAMPLE_W-1:0] s4_out_q;
	logic signed [WIDE_W-1:0]   scaled;
	logic signed [WIDE_W-1:0]   partner_w;
	logic signed [WIDE_W-1:0]   mixed;
	logic signed [WIDE_W-1:0]   shifted;
	logic        [SAMPLE_W-1:0] clamped;

	////////////////////////////////////////////////////////////
	// Stage 1 input scaling
	////////////////////////////////////////////////////////////

	// Offset binary loses its low bit and gets zero fill
	assign scaled = i_sample.is_signed ?
		{i_sample.core[SAMPLE_W-1], i_sample.core} :
		{2'b00, i_sample.core[SAMPLE_W-1:1]};

	////////////////////////////////////////////////////////////
	// Stage 3 crossfeed
	////////////////////////////////////////////////////////////

	assign partner_w = {i_partner_half[SAMPLE_W-1], i_partner_half};

	always_comb begin
		mixed = s2_sum_q;
		case (i_mix_mode)
			MIX_NONE:   mixed = s2_sum_q;
			MIX_LIGHT:  mixed = s2_sum_q - (s2_sum_q >>> 3) + (partner_w >>> 2);
			MIX_MEDIUM: mixed = s2_sum_q - (s2_sum_q >>> 2) + (partner_w >>> 1);
			MIX_MONO:   mixed = (s2_sum_q >>> 1) + partner_w;
			default:    mixed = s2_sum_q;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Stage 4 attenuation and clamp
	////////////////////////////////////////////////////////////

	always_comb begin
		if (i_att[ATT_W-1]) begin
			shifted = '0;
		end else begin
			shifted = s3_mix_q >>> i_att[ATT_W-2:0];
		end
		// Top two bits disagree means overflow
		if (shifted[WIDE_W-1] != shifted[WIDE_W-2]) begin
			clamped = {shifted[WIDE_W-1], {(SAMPLE_W-1){~shifted[WIDE_W-1]}}};
		end else begin
			clamped = shifted[SAMPLE_W-1:0];
		end
	end

	// Valid bits travel with the data
	always_ff @(posedge clk) begin
		if (resetd) begin
			v1_q <= 1'b0;
			v2_q <= 1'b0;
			v3_q <= 1'b0;
			v4_q <= 1'b0;
		end else if (i_advance) begin
			v1_q <= i_valid;
			v2_q <= v1_q;
			v3_q <= v2_q;
			v4_q <= v3_q;
		end
	end

	always_ff @(posedge clk) begin
		if (i_advance) begin
			s1_core_q <= scaled;
			s1_host_q <= i_sample.host;
			s2_sum_q  <= s1_core_q + $signed({s1_host_q[SAMPLE_W-1], s1_host_q});
			s3_mix_q  <= mixed;
			s4_out_q  <= clamped;
		end
	end

	assign o_half   = s2_sum_q[WIDE_W-1:1];
	assign o_valid  = v4_q;
	assign o_result = s4_out_q;

endmodule

/* source/frame_collector.sv */
/* Two-entry output FIFO in frame order. Advance is not-full and depends only on
   the stored count, so back-pressure has no combinational path to the output. */
module frame_collector
	import audio_mix_pkg::*;
(
	input  logic                                clk,
	input  logic                                resetd,
	input  logic                                i_valid,
	input  logic [N_CHANNELS-1:0][SAMPLE_W-1:0] i_result,
	input  logic                                i_out_ready,
	output logic                                o_advance,
	output logic                                o_out_valid,
	output out_frame_t                          o_out
);

	out_frame_t mem_q [2];
	logic       wr_ptr_q;
	logic       rd_ptr_q;
	logic [1:0] count_q;
	logic       full;
	logic       wr_en;
	logic       rd_en;
	out_frame_t wr_frame;

	assign full        = (count_q == 2'd2);
	assign o_advance   = ~full;
	assign o_out_valid = (count_q != 2'd0);

	assign wr_en = i_valid & o_advance;
	assign rd_en = o_out_valid & i_out_ready;

	assign wr_frame.sample = i_result;

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			wr_ptr_q <= 1'b0;
			rd_ptr_q <= 1'b0;
			count_q  <= 2'd0;
		end else begin
			if (wr_en) begin
				wr_ptr_q <= ~wr_ptr_q;
			end
			if (rd_en) begin
				rd_ptr_q <= ~rd_ptr_q;
			end
			case ({wr_en, rd_en})
				2'b10:   count_q <= count_q + 2'd1;
				2'b01:   count_q <= count_q - 2'd1;
				default: count_q <= count_q;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_q[wr_ptr_q] <= wr_frame;
		end
	end

	// Head entry stays put until it is read
	assign o_out = mem_q[rd_ptr_q];

endmodule

/* source/frame_splitter.sv */
/* Input register of the pipeline; holds whenever advance is low.
   A missing input frame enters as a bubble. */
module frame_splitter
	import audio_mix_pkg::*;
(
	input  logic                          clk,
	input  logic                          resetd,
	input  logic                          i_in_valid,
	input  in_frame_t                     i_in,
	input  logic                          i_advance,
	output logic                          o_in_ready,
	output logic                          o_stage_valid,
	output chan_sample_t [N_CHANNELS-1:0] o_chan
);

	logic      valid_q;
	in_frame_t frame_q;

	// Input moves only when the whole pipeline moves
	assign o_in_ready = i_advance;

	////////////////////////////////////////////////////////////
	// Frame register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			valid_q <= 1'b0;
		end else if (i_advance) begin
			valid_q <= i_in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_advance && i_in_valid) begin
			frame_q <= i_in;
		end
	end

	////////////////////////////////////////////////////////////
	// Per channel split
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int ch = 0; ch < N_CHANNELS; ch++) begin
			o_chan[ch].core      = frame_q.core[ch];
			o_chan[ch].host      = frame_q.host[ch];
			// Format flag is shared by every channel
			o_chan[ch].is_signed = frame_q.is_signed;
		end
	end

	assign o_stage_valid = valid_q;

endmodule

/* source/host_cmd_decoder.sv */
/* Start word carries the command in its low byte and later words are its data.
   Only volume data is kept; att moves one cycle after the data word. */
module host_cmd_decoder
	import audio_mix_pkg::*;
(
	input  logic             clk,
	input  logic             resetd,
	input  logic             i_host_valid,
	input  host_word_t       i_host,
	output logic             o_host_ready,
	output logic [ATT_W-1:0] o_att
);

	host_cmd_e        cmd_q;
	logic             has_cmd_q;
	logic             vol_wr_q;
	logic [ATT_W-1:0] vol_data_q;
	logic [ATT_W-1:0] att_q;
	logic             word_fire;
	logic             vol_word;

	// Decoder never stalls the host
	assign o_host_ready = 1'b1;
	assign word_fire    = i_host_valid & o_host_ready;

	// Data word that belongs to an open volume command
	assign vol_word = word_fire & ~i_host.start & has_cmd_q & (cmd_q == CMD_VOLUME);

	////////////////////////////////////////////////////////////
	// Command tracking
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			cmd_q     <= CMD_NONE;
			has_cmd_q <= 1'b0;
			vol_wr_q  <= 1'b0;
			att_q     <= '0;
		end else begin
			vol_wr_q <= vol_word;
			if (word_fire && i_host.start) begin
				cmd_q     <= host_cmd_e'(i_host.data[CMD_W-1:0]);
				has_cmd_q <= 1'b1;
			end
			// Second step of the volume update
			if (vol_wr_q) begin
				att_q <= vol_data_q;
			end
		end
	end

	// Captured volume value waiting for the write
	always_ff @(posedge clk) begin
		if (vol_word) begin
			vol_data_q <= i_host.data[ATT_W-1:0];
		end
	end

	assign o_att = att_q;

endmodule
